// ==== common/dcache_pkg.sv ====
package dcache_pkg;

  localparam int ADDR_W    = 12;
  localparam int TAG_W     = 4;
  localparam int INDEX_W   = 4;
  localparam int WORD_W    = 2;
  localparam int BYTE_W    = 2;
  localparam int NUM_LINES = 16;
  localparam int DATA_W    = 32;

  // controller states
  localparam int                 STATE_W   = 3;
  localparam logic [STATE_W-1:0] ST_IDLE   = 3'd0;
  localparam logic [STATE_W-1:0] ST_LOOKUP = 3'd1;
  localparam logic [STATE_W-1:0] ST_WBACK  = 3'd2;
  localparam logic [STATE_W-1:0] ST_REFILL = 3'd3;
  localparam logic [STATE_W-1:0] ST_FINISH = 3'd4;

  typedef struct packed {
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic [WORD_W-1:0]  word;
    logic [BYTE_W-1:0]  byte_off;
  } cpu_cache_view_t;

  // block number is tag and index taken together
  typedef struct packed {
    logic [TAG_W+INDEX_W-1:0] block;
    logic [WORD_W+BYTE_W-1:0] offset;
  } cpu_mem_view_t;

  typedef union packed {
    cpu_cache_view_t cache;
    cpu_mem_view_t   mem;
  } cpu_addr_u;

endpackage

// ==== common/mem_pkg.sv ====
package mem_pkg;

  // one cache line per DRAM access
  localparam int LINE_W = 128;

  // block number sent to the DRAM
  localparam int BLOCK_W = 8;

  // byte storage of the DRAM model
  localparam int MEM_DEPTH = 4096;

  // counter value at which mem_ready fires
  localparam logic [1:0] LAT_MAX = 2'd3;

endpackage

// ==== dcache/dcache_addr_decode.sv ====
module dcache_addr_decode (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           req,
  input  logic                           we,
  input  logic [dcache_pkg::ADDR_W-1:0]  addr,
  input  logic [dcache_pkg::DATA_W-1:0]  wdata,
  input  logic                           busy,
  output logic                           req_valid,
  output logic                           req_we,
  output logic [dcache_pkg::DATA_W-1:0]  req_wdata,
  output logic [dcache_pkg::TAG_W-1:0]   req_tag,
  output logic [dcache_pkg::INDEX_W-1:0] req_index,
  output logic [dcache_pkg::WORD_W-1:0]  req_word,
  output logic [mem_pkg::BLOCK_W-1:0]    req_block
);

  dcache_pkg::cpu_addr_u addr_q;
  logic                  accept;

  // a request while busy is dropped
  assign accept = req && !busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q    <= addr;
      req_we    <= we;
      req_wdata <= wdata;
    end
  end

  // cache fields and DRAM block come from the same captured word
  assign req_tag   = addr_q.cache.tag;
  assign req_index = addr_q.cache.index;
  assign req_word  = addr_q.cache.word;
  assign req_block = addr_q.mem.block;

endmodule

// ==== dcache/dcache_ctrl.sv ====
module dcache_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           req_valid,
  input  logic [dcache_pkg::INDEX_W-1:0] req_index,
  input  logic [mem_pkg::BLOCK_W-1:0]    req_block,
  input  logic                           hit,
  input  logic                           victim_dirty,
  input  logic [dcache_pkg::TAG_W-1:0]   victim_tag,
  input  logic                           mem_ready,
  output logic                           busy,
  output logic                           done,
  output logic                           lookup,
  output logic                           store_en,
  output logic                           refill_en,
  output logic                           mark_clean,
  output logic                           rden,
  output logic                           wren,
  output logic [mem_pkg::BLOCK_W-1:0]    mem_addr
);

  logic [dcache_pkg::STATE_W-1:0] state;
  logic [dcache_pkg::STATE_W-1:0] state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      dcache_pkg::ST_IDLE: begin
        if (req_valid) begin
          state_nxt = dcache_pkg::ST_LOOKUP;
        end
      end
      dcache_pkg::ST_LOOKUP: begin
        if (hit) begin
          state_nxt = dcache_pkg::ST_IDLE;
        end else if (victim_dirty) begin
          state_nxt = dcache_pkg::ST_WBACK;
        end else begin
          state_nxt = dcache_pkg::ST_REFILL;
        end
      end
      dcache_pkg::ST_WBACK: begin
        if (mem_ready) begin
          state_nxt = dcache_pkg::ST_REFILL;
        end
      end
      dcache_pkg::ST_REFILL: begin
        if (mem_ready) begin
          state_nxt = dcache_pkg::ST_FINISH;
        end
      end
      dcache_pkg::ST_FINISH: begin
        state_nxt = dcache_pkg::ST_IDLE;
      end
      default: begin
        state_nxt = dcache_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= dcache_pkg::ST_IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_nxt;
      // the access completes on a lookup hit or after the refilled line is in place
      done  <= (lookup && hit) || store_en;
    end
  end

  assign lookup   = (state == dcache_pkg::ST_LOOKUP);
  assign store_en = (state == dcache_pkg::ST_FINISH);

  // strobes drop in the cycle mem_ready is seen so the DRAM counter restarts clean
  assign wren = (state == dcache_pkg::ST_WBACK) && !mem_ready;
  assign rden = (state == dcache_pkg::ST_REFILL) && !mem_ready;

  assign mark_clean = (state == dcache_pkg::ST_WBACK) && mem_ready;
  assign refill_en  = (state == dcache_pkg::ST_REFILL) && mem_ready;

  // victim block during write-back, requested block otherwise
  assign mem_addr = (state == dcache_pkg::ST_WBACK) ? {victim_tag, req_index} : req_block;

  assign busy = req_valid || (state != dcache_pkg::ST_IDLE);

endmodule

// ==== dcache/dcache_line_store.sv ====
module dcache_line_store (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           lookup,
  input  logic                           store_en,
  input  logic                           refill_en,
  input  logic                           mark_clean,
  input  logic                           req_we,
  input  logic [dcache_pkg::TAG_W-1:0]   req_tag,
  input  logic [dcache_pkg::INDEX_W-1:0] req_index,
  input  logic [dcache_pkg::WORD_W-1:0]  req_word,
  input  logic [dcache_pkg::DATA_W-1:0]  req_wdata,
  input  logic [mem_pkg::LINE_W-1:0]     mem_rdata,
  output logic                           hit,
  output logic                           victim_dirty,
  output logic [dcache_pkg::TAG_W-1:0]   victim_tag,
  output logic [mem_pkg::LINE_W-1:0]     victim_line,
  output logic [dcache_pkg::DATA_W-1:0]  rdata
);

  logic [dcache_pkg::TAG_W-1:0] tag_mem  [dcache_pkg::NUM_LINES];
  logic [mem_pkg::LINE_W-1:0]   data_mem [dcache_pkg::NUM_LINES];
  logic [dcache_pkg::NUM_LINES-1:0] valid;
  logic [dcache_pkg::NUM_LINES-1:0] dirty;
  logic [mem_pkg::LINE_W-1:0]   cur_line;
  logic [mem_pkg::LINE_W-1:0]   merged_line;
  logic                         access;

  assign cur_line     = data_mem[req_index];
  assign victim_line  = cur_line;
  assign victim_tag   = tag_mem[req_index];
  assign victim_dirty = valid[req_index] && dirty[req_index];
  assign hit          = valid[req_index] && (tag_mem[req_index] == req_tag);

  // lookup hit, or the post-refill access
  assign access = (lookup && hit) || store_en;

  always_comb begin
    merged_line = cur_line;
    merged_line[req_word*dcache_pkg::DATA_W +: dcache_pkg::DATA_W] = req_wdata;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid <= '0;
      dirty <= '0;
    end else if (refill_en) begin
      valid[req_index] <= 1'b1;
      dirty[req_index] <= 1'b0;
    end else if (access && req_we) begin
      dirty[req_index] <= 1'b1;
    end else if (mark_clean) begin
      dirty[req_index] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (refill_en) begin
      tag_mem[req_index]  <= req_tag;
      data_mem[req_index] <= mem_rdata;
    end else if (access && req_we) begin
      data_mem[req_index] <= merged_line;
    end
  end

  // load word lands on the same edge that raises done
  always_ff @(posedge clk) begin
    if (access && !req_we) begin
      rdata <= cur_line[req_word*dcache_pkg::DATA_W +: dcache_pkg::DATA_W];
    end
  end

endmodule

// ==== hw/riscv_dram_model.sv ====
module riscv_dram_model (
  input  logic                        clk,
  input  logic                        wren,
  input  logic                        rden,
  input  logic [mem_pkg::BLOCK_W-1:0] addr,
  input  logic [mem_pkg::LINE_W-1:0]  data_in,
  output logic [mem_pkg::LINE_W-1:0]  data_out,
  output logic                        mem_ready
);

  logic [$clog2(mem_pkg::MEM_DEPTH)-1:0] base_addr;
  logic [7:0]                            mem [0:mem_pkg::MEM_DEPTH-1];
  logic [1:0]                            counter;

  initial begin
    for (int i = 0; i < mem_pkg::MEM_DEPTH; i++) begin
      mem[i] = 8'h00;
    end
  end

  // each block covers sixteen bytes
  assign base_addr = {addr, 4'b0000};

  // ready fires once the counter reaches its top value
  always_ff @(posedge clk) begin
    mem_ready <= 1'b0;
    if (counter == mem_pkg::LAT_MAX) begin
      counter   <= 2'b00;
      mem_ready <= 1'b1;
    end else if (wren || rden) begin
      counter <= counter + 2'b01;
    end else begin
      counter <= 2'b00;
    end
  end

  // byte 0 sits at the low end of the line
  always @(posedge clk) begin
    if (wren && !rden) begin
      for (int b = 0; b < mem_pkg::LINE_W / 8; b++) begin
        mem[base_addr + b] <= data_in[8*b +: 8];
      end
    end else if (rden && !wren) begin
      for (int b = 0; b < mem_pkg::LINE_W / 8; b++) begin
        data_out[8*b +: 8] <= mem[base_addr + b];
      end
    end
  end

endmodule

// ==== hw/dcache_top.sv ====
module dcache_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          req,
  input  logic                          we,
  input  logic [dcache_pkg::ADDR_W-1:0] addr,
  input  logic [dcache_pkg::DATA_W-1:0] wdata,
  output logic [dcache_pkg::DATA_W-1:0] rdata,
  output logic                          done,
  output logic                          busy
);

  logic                           req_valid;
  logic                           req_we;
  logic [dcache_pkg::DATA_W-1:0]  req_wdata;
  logic [dcache_pkg::TAG_W-1:0]   req_tag;
  logic [dcache_pkg::INDEX_W-1:0] req_index;
  logic [dcache_pkg::WORD_W-1:0]  req_word;
  logic [mem_pkg::BLOCK_W-1:0]    req_block;
  logic                           lookup;
  logic                           store_en;
  logic                           refill_en;
  logic                           mark_clean;
  logic                           hit;
  logic                           victim_dirty;
  logic [dcache_pkg::TAG_W-1:0]   victim_tag;
  logic [mem_pkg::LINE_W-1:0]     victim_line;
  logic                           rden;
  logic                           wren;
  logic [mem_pkg::BLOCK_W-1:0]    mem_addr;
  logic [mem_pkg::LINE_W-1:0]     mem_rdata;
  logic                           mem_ready;

  dcache_addr_decode u_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .we        (we),
    .addr      (addr),
    .wdata     (wdata),
    .busy      (busy),
    .req_valid (req_valid),
    .req_we    (req_we),
    .req_wdata (req_wdata),
    .req_tag   (req_tag),
    .req_index (req_index),
    .req_word  (req_word),
    .req_block (req_block)
  );

  dcache_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req_index    (req_index),
    .req_block    (req_block),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .mem_ready    (mem_ready),
    .busy         (busy),
    .done         (done),
    .lookup       (lookup),
    .store_en     (store_en),
    .refill_en    (refill_en),
    .mark_clean   (mark_clean),
    .rden         (rden),
    .wren         (wren),
    .mem_addr     (mem_addr)
  );

  dcache_line_store u_line_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookup       (lookup),
    .store_en     (store_en),
    .refill_en    (refill_en),
    .mark_clean   (mark_clean),
    .req_we       (req_we),
    .req_tag      (req_tag),
    .req_index    (req_index),
    .req_word     (req_word),
    .req_wdata    (req_wdata),
    .mem_rdata    (mem_rdata),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_line  (victim_line),
    .rdata        (rdata)
  );

  // write-back data is always the indexed victim line
  riscv_dram_model u_dram (
    .clk       (clk),
    .wren      (wren),
    .rden      (rden),
    .addr      (mem_addr),
    .data_in   (victim_line),
    .data_out  (mem_rdata),
    .mem_ready (mem_ready)
  );

endmodule

// ==== test/tb_clkgen.sv ====
module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // release on a falling edge after ten rising edges in reset
  initial begin
    rst_n = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== test/dcache_tb.sv ====
module dcache_tb;

  localparam int MAX_CASES  = 64;
  localparam int RAND_COUNT = 40;
  localparam int CYC_PER_OP = 30;

  // lookup 2, read 4, install and finish 2, write-back 4 plus one turnaround
  localparam int HIT_LAT        = 2;
  localparam int CLEAN_MISS_LAT = 8;
  localparam int DIRTY_MISS_LAT = 13;

  logic                          clk;
  logic                          rst_n;
  logic                          req;
  logic                          we;
  logic [dcache_pkg::ADDR_W-1:0] addr;
  logic [dcache_pkg::DATA_W-1:0] wdata;
  logic [dcache_pkg::DATA_W-1:0] rdata;
  logic                          done;
  logic                          busy;

  logic [31:0] case_words [0:3*MAX_CASES-1];
  logic [31:0] ref_mem [0:1023];
  logic [dcache_pkg::TAG_W-1:0] sh_tag [dcache_pkg::NUM_LINES];
  logic [dcache_pkg::NUM_LINES-1:0] sh_valid;
  logic [dcache_pkg::NUM_LINES-1:0] sh_dirty;

  int num_cases;
  int issued;
  int done_pulses;
  int data_errs;
  int lat_errs;
  int proto_errs;
  logic cases_loaded;
  logic [31:0] rng;
  logic rand_we;
  dcache_pkg::cpu_addr_u ra;

  tb_clkgen u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  dcache_top dcache_top_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .we    (we),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata),
    .done  (done),
    .busy  (busy)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic run_access(input logic is_store, input logic [11:0] a,
                            input logic [31:0] d, input logic from_file);
    dcache_pkg::cpu_addr_u ua;
    int lat;
    int exp_lat;
    logic [31:0] exp_word;
    ua = a;
    if (sh_valid[ua.cache.index] && sh_tag[ua.cache.index] == ua.cache.tag) begin
      exp_lat = HIT_LAT;
    end else if (sh_valid[ua.cache.index] && sh_dirty[ua.cache.index]) begin
      exp_lat = DIRTY_MISS_LAT;
    end else begin
      exp_lat = CLEAN_MISS_LAT;
    end
    exp_word = ref_mem[a[11:2]];
    @(negedge clk);
    req   = 1'b1;
    we    = is_store;
    addr  = a;
    wdata = is_store ? d : 32'h0;
    @(negedge clk);
    req = 1'b0;
    we  = 1'b0;
    lat = 0;
    while (!done) begin
      if (!busy) begin
        proto_errs++;
        $display("ERR %0t: busy low %0d cycles after req to 0x%03h", $time, lat, a);
      end
      @(negedge clk);
      lat++;
    end
    if (busy) begin
      proto_errs++;
      $display("ERR %0t: busy still high with done for 0x%03h", $time, a);
    end
    if (lat != exp_lat) begin
      lat_errs++;
      $display("ERR %0t: 0x%03h took %0d cycles, expected %0d", $time, a, lat, exp_lat);
    end
    if (!is_store) begin
      if (rdata != exp_word) begin
        data_errs++;
        $display("ERR %0t: load 0x%03h gave 0x%08h, model has 0x%08h",
                 $time, a, rdata, exp_word);
      end
      if (from_file && rdata != d) begin
        data_errs++;
        $display("ERR %0t: load 0x%03h gave 0x%08h, case expects 0x%08h",
                 $time, a, rdata, d);
      end
    end else begin
      ref_mem[a[11:2]] = d;
    end
    // a miss refills clean before any store lands
    if (exp_lat == HIT_LAT) begin
      sh_dirty[ua.cache.index] = sh_dirty[ua.cache.index] | is_store;
    end else begin
      sh_dirty[ua.cache.index] = is_store;
    end
    sh_valid[ua.cache.index] = 1'b1;
    sh_tag[ua.cache.index]   = ua.cache.tag;
    issued++;
  endtask

  always @(negedge clk) begin
    if (rst_n && done) begin
      done_pulses <= done_pulses + 1;
    end
  end

  initial begin
    wait (cases_loaded);
    wait (rst_n);
    repeat ((num_cases + RAND_COUNT) * CYC_PER_OP) @(posedge clk);
    $display("run timed out waiting for done after %0d requests", issued);
    $display("sim failed");
    $finish;
  end

  initial begin
    req          = 1'b0;
    we           = 1'b0;
    addr         = '0;
    wdata        = '0;
    cases_loaded = 1'b0;
    issued       = 0;
    done_pulses  = 0;
    data_errs    = 0;
    lat_errs     = 0;
    proto_errs   = 0;
    sh_valid     = '0;
    sh_dirty     = '0;
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = 32'h0;
    end
    for (int i = 0; i < 3 * MAX_CASES; i++) begin
      case_words[i] = 32'hffff_ffff;
    end
    $readmemh("test/dcache_cases.txt", case_words);
    num_cases = 0;
    while (num_cases < MAX_CASES && case_words[3*num_cases] != 32'hffff_ffff) begin
      num_cases++;
    end
    cases_loaded = 1'b1;

    wait (rst_n);
    @(negedge clk);
    if (done || busy) begin
      proto_errs++;
      $display("ERR %0t: done=%0b busy=%0b after reset", $time, done, busy);
    end

    for (int i = 0; i < num_cases; i++) begin
      run_access(case_words[3*i][0], case_words[3*i+1][11:0], case_words[3*i+2], 1'b1);
    end

    // conflicts over tags 0..2 at indexes 1 and 2
    rng = 32'd66063;
    for (int i = 0; i < RAND_COUNT; i++) begin
      rng = xorshift32(rng);
      ra.cache.tag      = 4'(rng % 3);
      ra.cache.index    = rng[4] ? 4'd1 : 4'd2;
      ra.cache.word     = rng[6:5];
      ra.cache.byte_off = 2'b00;
      rand_we = rng[7];
      rng = xorshift32(rng);
      run_access(rand_we, ra, rng, 1'b0);
    end

    repeat (3) @(negedge clk);
    if (done_pulses != issued) begin
      proto_errs++;
      $display("ERR %0t: %0d done pulses for %0d requests", $time, done_pulses, issued);
    end

    $display("errors: data %0d, latency %0d, protocol %0d", data_errs, lat_errs, proto_errs);
    if (data_errs == 0 && lat_errs == 0 && proto_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== test/dcache_cases.txt ====
// op (0 load, 1 store), byte address, data (store value or expected load word)
// all hex; tag is addr[11:8], index addr[7:4], word addr[3:2]
0 010 00000000
0 010 00000000
1 014 11111111
0 014 11111111
0 010 00000000
0 018 00000000
0 01c 00000000
1 024 a5a5a5a5
0 124 00000000
0 024 a5a5a5a5
0 020 00000000
0 028 00000000
0 02c 00000000
0 210 00000000
0 014 11111111
0 010 00000000
0 01c 00000000
1 038 12345678
1 03c 9abcdef0
0 138 00000000
0 03c 9abcdef0
0 038 12345678
0 030 00000000

// ==== sim.f ====
common/dcache_pkg.sv
common/mem_pkg.sv
dcache/dcache_addr_decode.sv
dcache/dcache_ctrl.sv
dcache/dcache_line_store.sv
hw/riscv_dram_model.sv
hw/dcache_top.sv
test/tb_clkgen.sv
test/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
